/* chdr_framer_pkg.sv */
`default_nettype none

package chdr_framer_pkg;

  // --------------------------------------------------------------------------
  // Bus widths and word types
  // --------------------------------------------------------------------------
  localparam int CHDR_W      = 64;  // One CHDR word per beat
  localparam int CTXT_USER_W = 4;   // Context field code width

  typedef logic [CHDR_W-1:0] chdr_word_t;

  // Context FIFO entry
  typedef struct packed {
    chdr_word_t             tdata;
    logic [CTXT_USER_W-1:0] tuser;  // Which context field this word is
    logic                   tlast;
  } ctxt_beat_t;

  // Payload FIFO entry
  typedef struct packed {
    chdr_word_t tdata;
    logic       tlast;
  } pyld_beat_t;

  // --------------------------------------------------------------------------
  // Context field codes and header fields
  // --------------------------------------------------------------------------
  localparam logic [CTXT_USER_W-1:0] CTXT_FIELD_HDR   = 4'd0;
  localparam logic [CTXT_USER_W-1:0] CTXT_FIELD_TS    = 4'd2;
  localparam logic [CTXT_USER_W-1:0] CTXT_FIELD_MDATA = 4'd3;

  localparam int PKT_TYPE_LSB  = 53;  // Header bits 55..53
  localparam int PKT_TYPE_W    = 3;
  localparam logic [PKT_TYPE_W-1:0] PKT_TYPE_DATA_TS = 3'd7;  // Data with timestamp

  localparam int NUM_MDATA_LSB = 48;  // Header bits 52..48
  localparam int NUM_MDATA_W   = 5;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int CTXT_PREFETCH   = 1;   // Context packets allowed ahead of payload
  localparam int CTXT_FIFO_DEPTH = 4;
  localparam int PYLD_FIFO_DEPTH = 8;
  localparam int GATE_DEPTH_LOG2 = 5;   // 32 words, largest packet
  localparam int PKT_CNT_W       = 3;
  localparam int ERR_CNT_W       = 32;

endpackage

`default_nettype wire

/* framer_admit.sv */
`default_nettype none

module framer_admit (
  input  wire logic axis_chdr_clk,
  input  wire logic axis_chdr_rst,
  input  wire logic i_ctxt_tvalid,
  input  wire logic i_ctxt_tlast,
  input  wire logic i_pyld_tvalid,
  input  wire logic i_pyld_tlast,
  input  wire logic i_ctxt_fifo_ready,
  input  wire logic i_pyld_fifo_ready,
  output logic      o_ctxt_tready,
  output logic      o_pyld_tready,
  output logic      o_ctxt_fifo_valid,
  output logic      o_pyld_fifo_valid
);
  import chdr_framer_pkg::*;

  // Context may run at most this many packets ahead of payload
  localparam logic [PKT_CNT_W-1:0] MAX_AHEAD = PKT_CNT_W'(1 + CTXT_PREFETCH);

  logic [PKT_CNT_W-1:0] ctxt_cnt_q, pyld_cnt_q;  // Wrapping packet counters
  logic [PKT_CNT_W-1:0] ahead;
  logic                 pass_ctxt, pass_pyld;

  assign ahead     = ctxt_cnt_q - pyld_cnt_q;  // Modulo difference
  assign pass_pyld = (ahead != '0);            // Payload needs its context first
  assign pass_ctxt = (ahead < MAX_AHEAD);      // One extra context prefetched

  assign o_ctxt_tready     = i_ctxt_fifo_ready && pass_ctxt;
  assign o_pyld_tready     = i_pyld_fifo_ready && pass_pyld;
  assign o_ctxt_fifo_valid = i_ctxt_tvalid && pass_ctxt;
  assign o_pyld_fifo_valid = i_pyld_tvalid && pass_pyld;

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      ctxt_cnt_q <= '0;
      pyld_cnt_q <= '0;
    end else begin
      if (i_ctxt_tvalid && o_ctxt_tready && i_ctxt_tlast)
        ctxt_cnt_q <= ctxt_cnt_q + 1'b1;  // Count on end of packet
      if (i_pyld_tvalid && o_pyld_tready && i_pyld_tlast)
        pyld_cnt_q <= pyld_cnt_q + 1'b1;
    end
  end

  a_ahead_bound: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    ahead <= MAX_AHEAD);

endmodule

`default_nettype wire

/* stream_fifo.sv */
`default_nettype none

module stream_fifo #(
  parameter type beat_t = logic,
  parameter int  DEPTH  = 4
) (
  input  wire logic  axis_chdr_clk,
  input  wire logic  axis_chdr_rst,
  input  wire beat_t i_beat,
  input  wire logic  i_valid,
  output logic       o_ready,
  output beat_t      o_beat,
  output logic       o_valid,
  input  wire logic  i_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  beat_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;            // Occupancy
  logic             wr_en, rd_en;

  assign o_ready = (count_q != CNT_W'(DEPTH));  // Ready whenever not full
  assign o_valid = (count_q != '0);
  assign o_beat  = mem[rd_ptr_q];
  assign wr_en   = i_valid && o_ready;
  assign rd_en   = o_valid && i_ready;

  always_ff @(posedge axis_chdr_clk) begin
    if (wr_en)
      mem[wr_ptr_q] <= i_beat;
  end

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en)  // Circular wrap at DEPTH
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (wr_en && !rd_en)
        count_q <= count_q + 1'b1;
      else if (rd_en && !wr_en)
        count_q <= count_q - 1'b1;
    end
  end

  // Occupancy stays in range, so no write lands on a full buffer or read on an empty one
  a_count_range: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    count_q <= CNT_W'(DEPTH));
  a_ptrs_match: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (count_q == '0 || count_q == CNT_W'(DEPTH)) |-> (wr_ptr_q == rd_ptr_q));

endmodule

`default_nettype wire

/* framer_fsm.sv */
`default_nettype none

module framer_fsm (
  input  wire logic                                  axis_chdr_clk,
  input  wire logic                                  axis_chdr_rst,
  input  wire chdr_framer_pkg::ctxt_beat_t           i_ctxt,
  input  wire logic                                  i_ctxt_valid,
  output logic                                       o_ctxt_ready,
  input  wire chdr_framer_pkg::pyld_beat_t           i_pyld,
  input  wire logic                                  i_pyld_valid,
  output logic                                       o_pyld_ready,
  output chdr_framer_pkg::chdr_word_t                o_gate_tdata,
  output logic                                       o_gate_tlast,
  output logic                                       o_gate_terror,
  output logic                                       o_gate_tvalid,
  input  wire logic                                  i_gate_tready,
  output logic [chdr_framer_pkg::ERR_CNT_W-1:0]      o_framer_errors
);
  import chdr_framer_pkg::*;

  typedef enum logic [2:0] {
    ST_HDR       = 3'd0,  // Header word to output
    ST_TS        = 3'd1,  // Timestamp word to output
    ST_MDATA     = 3'd2,  // Metadata words to output
    ST_BODY      = 3'd3,  // Payload words to output
    ST_DROP_CTXT = 3'd4,  // Discard rest of a bad context packet
    ST_DROP_PYLD = 3'd5,  // Discard the matching payload packet
    ST_TERMINATE = 3'd6   // Error word flushes the partial output packet
  } state_t;

  state_t                 state_q, ctxt_next;
  logic [NUM_MDATA_W-1:0] mdata_pending_q;  // Metadata words still due
  logic [PKT_TYPE_W-1:0]  pkt_type;
  logic [NUM_MDATA_W-1:0] num_mdata;
  logic                   has_ts, ctxt_xfer, pyld_xfer;

  assign pkt_type  = i_ctxt.tdata[PKT_TYPE_LSB +: PKT_TYPE_W];
  assign num_mdata = i_ctxt.tdata[NUM_MDATA_LSB +: NUM_MDATA_W];
  assign has_ts    = (pkt_type == PKT_TYPE_DATA_TS);
  assign ctxt_xfer = i_ctxt_valid && o_ctxt_ready;
  assign pyld_xfer = i_pyld_valid && o_pyld_ready;

  // Verdict on one context word, given whether more words must follow
  function automatic state_t check_word(input logic more, input logic user_ok,
                                        input logic last, input state_t good_next);
    if (more)
      return last ? ST_DROP_PYLD : (user_ok ? good_next : ST_DROP_CTXT);  // Early tlast
    else
      return last ? (user_ok ? ST_BODY : ST_DROP_PYLD) : ST_DROP_CTXT;     // Extra words
  endfunction

  // --------------------------------------------------------------------------
  // Context word classification
  // --------------------------------------------------------------------------
  always_comb begin
    case (state_q)
      ST_HDR:   ctxt_next = check_word(has_ts || (num_mdata != '0),
                                       i_ctxt.tuser == CTXT_FIELD_HDR, i_ctxt.tlast,
                                       has_ts ? ST_TS : ST_MDATA);
      ST_TS:    ctxt_next = check_word(mdata_pending_q != '0,
                                       i_ctxt.tuser == CTXT_FIELD_TS, i_ctxt.tlast, ST_MDATA);
      ST_MDATA: ctxt_next = check_word(mdata_pending_q > NUM_MDATA_W'(1),
                                       i_ctxt.tuser == CTXT_FIELD_MDATA, i_ctxt.tlast,
                                       ST_MDATA);
      default:  ctxt_next = i_ctxt.tlast ? ST_DROP_PYLD : ST_DROP_CTXT;  // Draining context
    endcase
  end

  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      state_q         <= ST_HDR;
      mdata_pending_q <= '0;
      o_framer_errors <= '0;
    end else begin
      case (state_q)
        ST_HDR, ST_TS, ST_MDATA, ST_DROP_CTXT: begin
          if (ctxt_xfer)
            state_q <= ctxt_next;
        end
        ST_BODY: begin
          if (pyld_xfer && i_pyld.tlast)
            state_q <= ST_HDR;  // Packet complete
        end
        ST_DROP_PYLD: begin
          if (pyld_xfer && i_pyld.tlast)
            state_q <= ST_TERMINATE;
        end
        ST_TERMINATE: begin
          if (i_gate_tready) begin
            state_q         <= ST_HDR;
            o_framer_errors <= o_framer_errors + 1'b1;  // One per rejected packet
          end
        end
        default: state_q <= ST_HDR;
      endcase
      if (ctxt_xfer && state_q == ST_HDR)
        mdata_pending_q <= num_mdata;
      else if (ctxt_xfer && state_q == ST_MDATA)
        mdata_pending_q <= mdata_pending_q - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Steering to the gate
  // --------------------------------------------------------------------------
  always_comb begin
    o_gate_tvalid = 1'b0;
    o_gate_tlast  = 1'b0;
    o_ctxt_ready  = 1'b0;
    o_pyld_ready  = 1'b0;
    case (state_q)
      ST_HDR, ST_TS, ST_MDATA: begin
        o_gate_tvalid = i_ctxt_valid;   // Context words go out, never last
        o_ctxt_ready  = i_gate_tready;
      end
      ST_BODY: begin
        o_gate_tvalid = i_pyld_valid;
        o_gate_tlast  = i_pyld.tlast;   // Packet end comes from payload
        o_pyld_ready  = i_gate_tready;
      end
      ST_DROP_CTXT: o_ctxt_ready = 1'b1;  // Consume without output
      ST_DROP_PYLD: o_pyld_ready = 1'b1;
      ST_TERMINATE: begin
        o_gate_tvalid = 1'b1;
        o_gate_tlast  = 1'b1;
      end
      default: ;
    endcase
  end

  assign o_gate_tdata  = (state_q == ST_BODY) ? i_pyld.tdata : i_ctxt.tdata;
  assign o_gate_terror = (state_q == ST_TERMINATE);

  a_state_legal: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    state_q inside {ST_HDR, ST_TS, ST_MDATA, ST_BODY, ST_DROP_CTXT, ST_DROP_PYLD,
                    ST_TERMINATE});

endmodule

`default_nettype wire

/* packet_gate.sv */
`default_nettype none

module packet_gate (
  input  wire logic                         axis_chdr_clk,
  input  wire logic                         axis_chdr_rst,
  input  wire chdr_framer_pkg::chdr_word_t  i_tdata,
  input  wire logic                         i_tlast,
  input  wire logic                         i_terror,
  input  wire logic                         i_tvalid,
  output logic                              o_tready,
  output chdr_framer_pkg::chdr_word_t       o_tdata,
  output logic                              o_tlast,
  output logic                              o_tvalid,
  input  wire logic                         i_tready
);
  import chdr_framer_pkg::*;

  localparam int AW    = GATE_DEPTH_LOG2;
  localparam int DEPTH = 2 ** GATE_DEPTH_LOG2;

  // Stored word with its end marker
  typedef struct packed {
    chdr_word_t tdata;
    logic       tlast;
  } entry_t;

  entry_t      mem [DEPTH];
  logic [AW:0] wr_ptr_q, cmt_ptr_q, rd_ptr_q;  // Extra bit tells full from empty
  logic        in_xfer, wr_en, full;
  entry_t      rd_entry;

  assign full     = ((wr_ptr_q - rd_ptr_q) == (AW+1)'(DEPTH));
  assign o_tready = !full;
  assign in_xfer  = i_tvalid && o_tready;
  assign wr_en    = in_xfer && !i_terror;  // Error beat is never stored

  // Only committed words are visible
  assign o_tvalid = (rd_ptr_q != cmt_ptr_q);
  assign rd_entry = mem[rd_ptr_q[AW-1:0]];
  assign o_tdata  = rd_entry.tdata;
  assign o_tlast  = rd_entry.tlast;

  always_ff @(posedge axis_chdr_clk) begin
    if (wr_en)
      mem[wr_ptr_q[AW-1:0]] <= '{tdata: i_tdata, tlast: i_tlast};
  end

  // --------------------------------------------------------------------------
  // Pointer control
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr_q  <= '0;
      cmt_ptr_q <= '0;
      rd_ptr_q  <= '0;
    end else begin
      if (in_xfer && i_terror) begin
        wr_ptr_q <= cmt_ptr_q;           // Rewind, partial packet discarded
      end else if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        if (i_tlast)
          cmt_ptr_q <= wr_ptr_q + 1'b1;  // Whole packet released
      end
      if (o_tvalid && i_tready)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // A packet longer than the buffer stalls with nothing left to drain
  a_no_overlong_pkt: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    !(!o_tready && ((wr_ptr_q - cmt_ptr_q) == (AW+1)'(DEPTH))));

endmodule

`default_nettype wire

/* chdr_framer.sv */
`default_nettype none

module chdr_framer (
  input  wire logic                                       axis_chdr_clk,
  input  wire logic                                       axis_chdr_rst,
  // Context stream in
  input  wire chdr_framer_pkg::chdr_word_t                i_ctxt_tdata,
  input  wire logic [chdr_framer_pkg::CTXT_USER_W-1:0]    i_ctxt_tuser,
  input  wire logic                                       i_ctxt_tlast,
  input  wire logic                                       i_ctxt_tvalid,
  output logic                                            o_ctxt_tready,
  // Payload stream in
  input  wire chdr_framer_pkg::chdr_word_t                i_pyld_tdata,
  input  wire logic                                       i_pyld_tlast,
  input  wire logic                                       i_pyld_tvalid,
  output logic                                            o_pyld_tready,
  // CHDR stream out
  output chdr_framer_pkg::chdr_word_t                     o_chdr_tdata,
  output logic                                            o_chdr_tlast,
  output logic                                            o_chdr_tvalid,
  input  wire logic                                       i_chdr_tready,
  // Status
  output logic [chdr_framer_pkg::ERR_CNT_W-1:0]           o_framer_errors
);
  import chdr_framer_pkg::*;

  logic       ctxt_in_valid, ctxt_in_ready;  // Admission to context FIFO
  logic       pyld_in_valid, pyld_in_ready;  // Admission to payload FIFO
  ctxt_beat_t ctxt_beat;
  pyld_beat_t pyld_beat;
  logic       ctxt_valid, ctxt_ready;
  logic       pyld_valid, pyld_ready;
  chdr_word_t gate_tdata;
  logic       gate_tlast, gate_terror, gate_tvalid, gate_tready;

  // --------------------------------------------------------------------------
  // Interleaving and input FIFOs
  // --------------------------------------------------------------------------
  framer_admit admit_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt_tvalid, .i_ctxt_tlast, .i_pyld_tvalid, .i_pyld_tlast,
    .i_ctxt_fifo_ready(ctxt_in_ready), .i_pyld_fifo_ready(pyld_in_ready),
    .o_ctxt_tready, .o_pyld_tready,
    .o_ctxt_fifo_valid(ctxt_in_valid), .o_pyld_fifo_valid(pyld_in_valid)
  );

  stream_fifo #(.beat_t(ctxt_beat_t), .DEPTH(CTXT_FIFO_DEPTH)) ctxt_fifo_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_beat({i_ctxt_tdata, i_ctxt_tuser, i_ctxt_tlast}),  // Field order of ctxt_beat_t
    .i_valid(ctxt_in_valid), .o_ready(ctxt_in_ready),
    .o_beat(ctxt_beat), .o_valid(ctxt_valid), .i_ready(ctxt_ready)
  );

  stream_fifo #(.beat_t(pyld_beat_t), .DEPTH(PYLD_FIFO_DEPTH)) pyld_fifo_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_beat({i_pyld_tdata, i_pyld_tlast}),
    .i_valid(pyld_in_valid), .o_ready(pyld_in_ready),
    .o_beat(pyld_beat), .o_valid(pyld_valid), .i_ready(pyld_ready)
  );

  // --------------------------------------------------------------------------
  // Framing and output gate
  // --------------------------------------------------------------------------
  framer_fsm fsm_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt(ctxt_beat), .i_ctxt_valid(ctxt_valid), .o_ctxt_ready(ctxt_ready),
    .i_pyld(pyld_beat), .i_pyld_valid(pyld_valid), .o_pyld_ready(pyld_ready),
    .o_gate_tdata(gate_tdata), .o_gate_tlast(gate_tlast), .o_gate_terror(gate_terror),
    .o_gate_tvalid(gate_tvalid), .i_gate_tready(gate_tready),
    .o_framer_errors
  );

  packet_gate gate_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_tdata(gate_tdata), .i_tlast(gate_tlast), .i_terror(gate_terror),
    .i_tvalid(gate_tvalid), .o_tready(gate_tready),
    .o_tdata(o_chdr_tdata), .o_tlast(o_chdr_tlast), .o_tvalid(o_chdr_tvalid),
    .i_tready(i_chdr_tready)
  );

endmodule

`default_nettype wire

/* tb_chdr_framer.sv */
`default_nettype none

module tb_chdr_framer;
  timeunit 1ns;
  timeprecision 1ps;
  import chdr_framer_pkg::*;

  localparam int PERIOD        = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int BEAT_TIMEOUT  = 400;   // Cycles one input beat may wait for ready
  localparam int DRAIN_TIMEOUT = 4000;  // Cycles for a whole test to flush out

  typedef enum int {FAULT_NONE, FAULT_USER, FAULT_EARLY_LAST} fault_t;

  logic                   axis_chdr_clk;
  logic                   axis_chdr_rst;
  chdr_word_t             i_ctxt_tdata;
  logic [CTXT_USER_W-1:0] i_ctxt_tuser;
  logic                   i_ctxt_tlast;
  logic                   i_ctxt_tvalid;
  logic                   o_ctxt_tready;
  chdr_word_t             i_pyld_tdata;
  logic                   i_pyld_tlast;
  logic                   i_pyld_tvalid;
  logic                   o_pyld_tready;
  chdr_word_t             o_chdr_tdata;
  logic                   o_chdr_tlast;
  logic                   o_chdr_tvalid;
  logic                   i_chdr_tready;
  logic [ERR_CNT_W-1:0]   o_framer_errors;

  ctxt_beat_t ctxt_src_q[$];  // Context beats still to drive
  pyld_beat_t pyld_src_q[$];  // Payload beats still to drive
  pyld_beat_t exp_q[$];       // Words expected at the CHDR output
  pyld_beat_t exp_head;
  logic       exp_any;
  int         err_exp;
  int         ahead_cnt;      // Context packets accepted minus payload packets
  integer     seed = 32'h340e_dd87;
  string      test_name;

  initial begin
    axis_chdr_clk = 1'b0;
    forever #(PERIOD / 2) axis_chdr_clk = ~axis_chdr_clk;
  end

  chdr_framer dut_i (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_ctxt_tdata, .i_ctxt_tuser, .i_ctxt_tlast, .i_ctxt_tvalid, .o_ctxt_tready,
    .i_pyld_tdata, .i_pyld_tlast, .i_pyld_tvalid, .o_pyld_tready,
    .o_chdr_tdata, .o_chdr_tlast, .o_chdr_tvalid, .i_chdr_tready,
    .o_framer_errors
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic void refresh_head();
    exp_any = (exp_q.size() != 0);
    if (exp_any)
      exp_head = exp_q[0];
  endfunction

  function automatic void expect_word(input chdr_word_t data, input logic last,
                                      input fault_t fault);
    if (fault == FAULT_NONE)  // Rejected packets leave nothing at the output
      exp_q.push_back(pyld_beat_t'{data, last});
  endfunction

  // Queue one packet's context and payload beats, and its expected output words
  task automatic build_packet(input int id, input logic has_ts, input int n_mdata,
                              input int n_pyld, input fault_t fault);
    chdr_word_t             hdr;
    chdr_word_t             word;
    logic                   hdr_last;
    logic [CTXT_USER_W-1:0] user;
    hdr = '0;
    hdr[PKT_TYPE_LSB +: PKT_TYPE_W]   = has_ts ? PKT_TYPE_DATA_TS : PKT_TYPE_W'(6);
    hdr[NUM_MDATA_LSB +: NUM_MDATA_W] = NUM_MDATA_W'(n_mdata);
    hdr[15:0] = 16'(id);  // Sequence number
    hdr_last = (!has_ts && n_mdata == 0) || (fault == FAULT_EARLY_LAST);
    ctxt_src_q.push_back(ctxt_beat_t'{hdr, CTXT_FIELD_HDR, hdr_last});
    expect_word(hdr, 1'b0, fault);
    if (!hdr_last && has_ts) begin
      word = 64'h7150_0000_0000_0000 | 64'(id);
      ctxt_src_q.push_back(ctxt_beat_t'{word, CTXT_FIELD_TS, n_mdata == 0});
      expect_word(word, 1'b0, fault);
    end
    for (int i = 0; i < n_mdata && !hdr_last; i++) begin
      word = 64'h3D00_0000_0000_0000 | (64'(id) << 8) | 64'(i);
      user = (fault == FAULT_USER && i == 0) ? CTXT_USER_W'(1) : CTXT_FIELD_MDATA;
      ctxt_src_q.push_back(ctxt_beat_t'{word, user, i == n_mdata - 1});
      expect_word(word, 1'b0, fault);
    end
    for (int i = 0; i < n_pyld; i++) begin
      word = 64'hDA7A_0000_0000_0000 | (64'(id) << 16) | 64'(i);
      pyld_src_q.push_back(pyld_beat_t'{word, i == n_pyld - 1});
      expect_word(word, i == n_pyld - 1, fault);  // Packet ends on last payload word
    end
    if (fault != FAULT_NONE)
      err_exp++;
    refresh_head();
  endtask

  // Hold the current beat until ready is seen 1 ns after a drive
  task automatic await_handshake(input logic is_ctxt, input string what);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken) begin
      #1;
      taken = is_ctxt ? o_ctxt_tready : o_pyld_tready;
      @(posedge axis_chdr_clk);
      #2;
      waited++;
      if (!taken && waited >= BEAT_TIMEOUT)
        abort_run($sformatf("%s beat was not accepted within %0d cycles in %s",
                            what, BEAT_TIMEOUT, test_name));
    end
  endtask

  task automatic drive_ctxt_stream();
    ctxt_beat_t beat;
    while (ctxt_src_q.size() != 0) begin
      beat          = ctxt_src_q.pop_front();
      i_ctxt_tdata  = beat.tdata;
      i_ctxt_tuser  = beat.tuser;
      i_ctxt_tlast  = beat.tlast;
      i_ctxt_tvalid = 1'b1;
      await_handshake(1'b1, "Context");
    end
    i_ctxt_tvalid = 1'b0;
  endtask

  task automatic drive_pyld_stream();
    pyld_beat_t beat;
    while (pyld_src_q.size() != 0) begin
      beat          = pyld_src_q.pop_front();
      i_pyld_tdata  = beat.tdata;
      i_pyld_tlast  = beat.tlast;
      i_pyld_tvalid = 1'b1;
      await_handshake(1'b0, "Payload");
    end
    i_pyld_tvalid = 1'b0;
  endtask

  // Run until every beat is driven and every expected word is out
  task automatic drain_outputs(input logic rand_ready);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || ctxt_src_q.size() != 0 || pyld_src_q.size() != 0) begin
      if (rand_ready)
        i_chdr_tready = 1'($random(seed));  // Random output back-pressure
      @(posedge axis_chdr_clk);
      #2;
      waited++;
      if (waited >= DRAIN_TIMEOUT)
        abort_run($sformatf("Output did not finish within %0d cycles in %s",
                            DRAIN_TIMEOUT, test_name));
    end
    i_chdr_tready = 1'b1;
  endtask

  task automatic run_stimulus(input logic rand_ready);
    fork
      drive_ctxt_stream();
      drive_pyld_stream();
      drain_outputs(rand_ready);
    join
    assert (o_framer_errors == ERR_CNT_W'(err_exp))
      else abort_run($sformatf("Mismatch in %s: expected errors %0d, actual %0d",
                               test_name, err_exp, o_framer_errors));
  endtask

  // --------------------------------------------------------------------------
  // Output tracking and checks
  // --------------------------------------------------------------------------
  always @(posedge axis_chdr_clk) begin
    if (!axis_chdr_rst && o_chdr_tvalid && i_chdr_tready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  always @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst)
      ahead_cnt <= 0;
    else
      ahead_cnt <= ahead_cnt + int'(i_ctxt_tvalid && o_ctxt_tready && i_ctxt_tlast)
                             - int'(i_pyld_tvalid && o_pyld_tready && i_pyld_tlast);
  end

  a_out_expected: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (o_chdr_tvalid && i_chdr_tready) |-> exp_any)
    else abort_run($sformatf("Unexpected output word %h in %s",
                             $sampled(o_chdr_tdata), test_name));

  a_out_match: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (o_chdr_tvalid && i_chdr_tready && exp_any) |->
      (o_chdr_tdata == exp_head.tdata && o_chdr_tlast == exp_head.tlast))
    else abort_run($sformatf("Mismatch in %s: expected %h last %b, actual %h last %b",
                             test_name, $sampled(exp_head.tdata), $sampled(exp_head.tlast),
                             $sampled(o_chdr_tdata), $sampled(o_chdr_tlast)));

  a_pyld_held: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (ahead_cnt == 0) |-> !o_pyld_tready)
    else abort_run($sformatf("Payload ready was high with no context ahead in %s", test_name));

  a_ctxt_held: assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (ahead_cnt >= 1 + CTXT_PREFETCH) |-> !o_ctxt_tready)
    else abort_run($sformatf("Context ready was high beyond the prefetch limit in %s",
                             test_name));

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    axis_chdr_rst = 1'b1;
    i_ctxt_tdata  = '0;
    i_ctxt_tuser  = '0;
    i_ctxt_tlast  = 1'b0;
    i_ctxt_tvalid = 1'b0;
    i_pyld_tdata  = '0;
    i_pyld_tlast  = 1'b0;
    i_pyld_tvalid = 1'b0;
    i_chdr_tready = 1'b1;
    err_exp       = 0;
    test_name     = "reset";
    refresh_head();
    repeat (RESET_CYCLES) @(posedge axis_chdr_clk);
    #2;
    axis_chdr_rst = 1'b0;
    assert (!o_chdr_tvalid && o_framer_errors == '0 && !o_pyld_tready)
      else abort_run("Outputs were not idle after reset");

    test_name = "plain_packet";
    build_packet(1, 1'b0, 0, 4, FAULT_NONE);
    run_stimulus(1'b0);

    test_name = "ts_mdata_packet";
    build_packet(2, 1'b1, 2, 5, FAULT_NONE);
    run_stimulus(1'b0);

    test_name = "bad_tuser";  // Bad metadata code followed by a good packet
    build_packet(3, 1'b1, 2, 3, FAULT_USER);
    build_packet(4, 1'b0, 1, 3, FAULT_NONE);
    run_stimulus(1'b0);

    test_name = "early_tlast";  // Header announces metadata but ends the context
    build_packet(5, 1'b0, 2, 3, FAULT_EARLY_LAST);
    build_packet(6, 1'b1, 0, 2, FAULT_NONE);
    run_stimulus(1'b0);

    test_name = "backpressure";
    for (int i = 0; i < 12; i++)
      build_packet(10 + i, 1'(i % 2), i % 4, 1 + (i * 5) % 13, FAULT_NONE);
    run_stimulus(1'b1);

    repeat (4) @(posedge axis_chdr_clk);  // Nothing stray may follow
    #2;
    if (exp_q.size() == 0 && o_framer_errors == ERR_CNT_W'(err_exp)) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("Expected words or error count left over at the end");
    end
  end

endmodule

`default_nettype wire

/* chdr_framer.f */
chdr_framer_pkg.sv
framer_admit.sv
stream_fifo.sv
framer_fsm.sv
packet_gate.sv
chdr_framer.sv
tb_chdr_framer.sv

/* Bender.yml */
package:
  name: chdr_framer

sources:
  - chdr_framer_pkg.sv
  - framer_admit.sv
  - stream_fifo.sv
  - framer_fsm.sv
  - packet_gate.sv
  - chdr_framer.sv
  - target: simulation
    files:
      - tb_chdr_framer.sv
